//--- tb/memory2_patterns.txt
# step port op addr wdata expect flag; step 1 opens a new cycle, 0 joins it
# op 0 idle, 1 read, 2 write; addr, wdata and expect in hex, flag 0 or 1
# Fibonacci words, bank 0 through port 0 and bank 5 through port 1
1 0 2 0000 00001 00000 0
0 1 2 1400 00001 00000 0
1 0 2 0001 00001 00000 0
0 1 2 1401 00002 00000 0
1 0 2 0002 00002 00000 0
0 1 2 1402 00003 00000 0
1 0 2 0003 00003 00000 0
0 1 2 1403 00005 00000 0
1 0 2 0004 00005 00000 0
0 1 2 1404 00008 00000 0
1 0 2 77FF 2AAAA 00000 0
0 1 2 0BFF 15555 00000 0
# Back to back reads through the other port
1 0 1 1400 00000 00001 0
0 1 1 0000 00000 00001 0
1 0 1 1401 00000 00002 0
0 1 1 0001 00000 00001 0
1 0 1 1402 00000 00003 0
0 1 1 0002 00000 00002 0
1 0 1 1403 00000 00005 0
0 1 1 0003 00000 00003 0
1 0 1 1404 00000 00008 0
0 1 1 0004 00000 00005 0
1 0 1 0BFF 00000 15555 0
0 1 1 77FF 00000 2AAAA 0
# Write collision, port 1 data stays
1 0 2 3010 11111 00000 0
0 1 2 3010 22222 00000 0
1 0 1 3010 00000 22222 0
# Read while the other port writes the same word
1 0 1 0002 00000 00002 0
0 1 2 0002 3ABCD 00000 0
1 0 1 0002 00000 3ABCD 0
1 1 1 1400 00000 00001 0
0 0 2 1400 12345 00000 0
1 1 1 1400 00000 12345 0
# Missing banks
1 0 1 7800 00000 00000 1
0 1 1 7C05 00000 00000 1
1 0 2 7800 3FFFF 00000 0
0 1 2 7C04 3FFFF 00000 0
1 0 1 0000 00000 00001 0
0 1 1 0004 00000 00005 0
# Idle cycles hold the last words
1 0 0 0000 00000 00000 0
1 0 0 0000 00000 00000 0
1 1 0 0000 00000 00000 0

//--- verilog.f
+incdir+verilog
verilog/mem_types_pkg.sv
verilog/mem_bus_pkg.sv
verilog/mem_port_front.sv
verilog/mem_bank_array.sv
verilog/mem_read_return.sv
verilog/memory2.sv
tb/memory2_tb.sv

//--- Makefile
# Verilator build and run of the memory2 testbench

VERILATOR ?= verilator
TOP       ?= memory2_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Exit status of the simulation is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- tb/memory2_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_defines.svh"

module memory2_tb
	import mem_types_pkg::*;
();

	localparam int OP_IDLE = 0;
	localparam int OP_READ = 1;
	localparam int OP_WRITE = 2;
	// Queue depth at which the oldest entry shows on the outputs
	localparam int PIPE_DEPTH = 4;
	localparam int RESET_CYCLES = 16;
	localparam int RESET_TIMEOUT = 8;
	localparam int MAX_LINES = 10000;
	localparam int RANDOM_CYCLES = 400;
	localparam string PATTERN_FILE = "tb/memory2_patterns.txt";

	// One expected output event per port and cycle
	typedef struct packed {
		logic      read;
		logic      flag;
		mem_data_t data;
	} expect_t;

	logic      clk;
	logic      rst;
	logic      en0, we0, range_err0;
	logic      en1, we1, range_err1;
	mem_addr_t addr0, addr1;
	mem_data_t data0, data1, out0, out1;

	// Request of the next cycle for each port
	int        op_v [2];
	mem_addr_t addr_v [2];
	mem_data_t wdata_v [2];
	mem_data_t expd_v [2];
	logic      flag_v [2];

	// Expectations in flight
	expect_t   exp_q0 [$];
	expect_t   exp_q1 [$];
	mem_data_t last0, last1;

	// Reference contents for the random phase
	mem_data_t shadow [1 << `MEM_ADDR_W];
	integer    seed = 90;

	memory2 memory2_i (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_data(input string name, input mem_data_t actual,
		input mem_data_t expected);
		if (actual !== expected) begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("[ERROR] %0t %s: got %b, expected %b", $time, name, actual, expected);
			abort_run();
		end
	endtask

	function automatic expect_t make_expect(input int op, input logic flag, input mem_data_t data);
		expect_t e;
		e.read = (op == OP_READ);
		e.flag = flag;
		e.data = data;
		return e;
	endfunction

	// Banks 30 and 31 name no storage
	function automatic logic addr_in_range(input mem_addr_t addr);
		return int'(addr >> `MEM_OFFSET_W) < `MEM_BANK_COUNT;
	endfunction

	////////////////////////////////////////////////////////////////////////
	// Cycle driver
	////////////////////////////////////////////////////////////////////////

	task automatic clear_request();
		for (int p = 0; p < 2; p++) begin
			op_v[p] = OP_IDLE;
			addr_v[p] = '0;
			wdata_v[p] = '0;
			expd_v[p] = '0;
			flag_v[p] = 1'b0;
		end
	endtask

	task automatic run_cycle();
		expect_t due0;
		expect_t due1;
		@(posedge clk);
		en0   <= (op_v[0] != OP_IDLE);
		we0   <= (op_v[0] == OP_WRITE);
		addr0 <= addr_v[0];
		data0 <= wdata_v[0];
		en1   <= (op_v[1] != OP_IDLE);
		we1   <= (op_v[1] == OP_WRITE);
		addr1 <= addr_v[1];
		data1 <= wdata_v[1];
		exp_q0.push_back(make_expect(op_v[0], flag_v[0], expd_v[0]));
		exp_q1.push_back(make_expect(op_v[1], flag_v[1], expd_v[1]));
		// Outputs are stable at the falling edge
		@(negedge clk);
		due0 = '0;
		due1 = '0;
		if (exp_q0.size() == PIPE_DEPTH)
			due0 = exp_q0.pop_front();
		if (exp_q1.size() == PIPE_DEPTH)
			due1 = exp_q1.pop_front();
		// No read means out holds
		if (due0.read)
			last0 = due0.data;
		if (due1.read)
			last1 = due1.data;
		check_data("out0", out0, last0);
		check_flag("range_err0", range_err0, due0.read & due0.flag);
		check_data("out1", out1, last1);
		check_flag("range_err1", range_err1, due1.read & due1.flag);
		clear_request();
	endtask

	task automatic apply_reset();
		int waited;
		@(posedge clk);
		rst <= 1'b1;
		en0 <= 1'b0;
		en1 <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		exp_q0.delete();
		exp_q1.delete();
		last0 = '0;
		last1 = '0;
		waited = 0;
		@(negedge clk);
		while (out0 !== '0 || out1 !== '0 || range_err0 !== 1'b0 || range_err1 !== 1'b0) begin
			if (waited == RESET_TIMEOUT) begin
				$display("Outputs were not cleared %0d cycles after reset", RESET_TIMEOUT);
				abort_run();
			end
			waited++;
			@(negedge clk);
		end
	endtask

	////////////////////////////////////////////////////////////////////////
	// Pattern phase
	////////////////////////////////////////////////////////////////////////

	task automatic run_patterns();
		int        fd;
		int        n;
		int        lines;
		int        step, port, op, fl;
		mem_addr_t a;
		mem_data_t wd, ex;
		string     line;
		logic      pending;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open %s", PATTERN_FILE);
			abort_run();
		end
		pending = 1'b0;
		lines = 0;
		while (!$feof(fd)) begin
			if (lines == MAX_LINES) begin
				$display("Pattern file did not end within %0d lines", MAX_LINES);
				abort_run();
			end
			lines++;
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%d %d %d %h %h %h %d", step, port, op, a, wd, ex, fl);
				if (n != 7 || port > 1 || op > OP_WRITE) begin
					$display("Bad pattern line %0d", lines);
					abort_run();
				end
				// Step 1 closes the cycle gathered so far
				if (step != 0 && pending)
					run_cycle();
				op_v[port] = op;
				addr_v[port] = a;
				wdata_v[port] = wd;
				expd_v[port] = ex;
				flag_v[port] = (fl != 0);
				pending = 1'b1;
			end
		end
		if (pending)
			run_cycle();
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////////////////
	// Random phase
	////////////////////////////////////////////////////////////////////////

	// Pool of banks 0 to 3 and 29 plus missing banks 30 and 31
	function automatic mem_addr_t pool_addr(input int bank_sel, input int word);
		mem_bank_t bank;
		case (bank_sel)
			0, 1, 2, 3: bank = mem_bank_t'(bank_sel);
			4: bank = mem_bank_t'(29);
			5: bank = mem_bank_t'(30);
			default: bank = mem_bank_t'(31);
		endcase
		return {bank, mem_offset_t'(word)};
	endfunction

	task automatic random_request(input int p);
		logic [31:0] rnd;
		rnd = $random(seed);
		case (rnd[1:0])
			2'd0: op_v[p] = OP_IDLE;
			2'd3: op_v[p] = OP_WRITE;
			default: op_v[p] = OP_READ;
		endcase
		addr_v[p] = pool_addr(int'(rnd[4:2]), int'(rnd[7:5]));
		wdata_v[p] = mem_data_t'(rnd >> 14);
	endtask

	// Reads see the array before this cycle's writes
	task automatic model_cycle();
		for (int p = 0; p < 2; p++) begin
			expd_v[p] = '0;
			flag_v[p] = 1'b0;
			if (op_v[p] == OP_READ && addr_in_range(addr_v[p]))
				expd_v[p] = shadow[addr_v[p]];
			else if (op_v[p] == OP_READ)
				flag_v[p] = 1'b1;
		end
		// Port 1 goes last so its word stands after a collision
		for (int p = 0; p < 2; p++) begin
			if (op_v[p] == OP_WRITE && addr_in_range(addr_v[p]))
				shadow[addr_v[p]] = wdata_v[p];
		end
	endtask

	task automatic run_random();
		// Fill all 40 in-range pool words first
		for (int w = 0; w < 40; w += 2) begin
			for (int p = 0; p < 2; p++) begin
				op_v[p] = OP_WRITE;
				addr_v[p] = pool_addr((w + p) / 8, (w + p) % 8);
				wdata_v[p] = mem_data_t'($random(seed));
			end
			model_cycle();
			run_cycle();
		end
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			random_request(0);
			random_request(1);
			model_cycle();
			run_cycle();
		end
	endtask

	initial begin
		rst   <= 1'b1;
		en0   <= 1'b0;
		we0   <= 1'b0;
		addr0 <= '0;
		data0 <= '0;
		en1   <= 1'b0;
		we1   <= 1'b0;
		addr1 <= '0;
		data1 <= '0;
		clear_request();
		apply_reset();
		run_patterns();
		repeat (PIPE_DEPTH) run_cycle();
		// Second reset mid run
		apply_reset();
		run_random();
		repeat (PIPE_DEPTH) run_cycle();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/memory2.sv
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Shared instruction and data memory
// Port 0 fetches instructions and port 1 serves data
////////////////////////////////////////////////////////////////////////////

module memory2
	import mem_types_pkg::*, mem_bus_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	// Instruction port
	input  logic      en0,
	input  logic      we0,
	input  mem_addr_t addr0,
	input  mem_data_t data0,
	output mem_data_t out0,
	output logic      range_err0,
	// Data port
	input  logic      en1,
	input  logic      we1,
	input  mem_addr_t addr1,
	input  mem_data_t data1,
	output mem_data_t out1,
	output logic      range_err1
);

	// Decoded requests into the array
	mem_req_t req0;
	mem_req_t req1;

	// Read responses out of the array
	mem_rsp_t rsp0;
	mem_rsp_t rsp1;

	////////////////////////////////////////////////////////////////////////
	// Request stage
	////////////////////////////////////////////////////////////////////////

	mem_port_front front0_i (
		.clk  (clk),
		.rst  (rst),
		.en   (en0),
		.we   (we0),
		.addr (addr0),
		.data (data0),
		.req  (req0)
	);

	mem_port_front front1_i (
		.clk  (clk),
		.rst  (rst),
		.en   (en1),
		.we   (we1),
		.addr (addr1),
		.data (data1),
		.req  (req1)
	);

	// Storage one cycle after the request stage
	mem_bank_array array_i (
		.clk  (clk),
		.rst  (rst),
		.req0 (req0),
		.req1 (req1),
		.rsp0 (rsp0),
		.rsp1 (rsp1)
	);

	////////////////////////////////////////////////////////////////////////
	// Return stage
	////////////////////////////////////////////////////////////////////////

	mem_read_return return0_i (
		.clk       (clk),
		.rst       (rst),
		.rsp       (rsp0),
		.out       (out0),
		.range_err (range_err0)
	);

	mem_read_return return1_i (
		.clk       (clk),
		.rst       (rst),
		.rsp       (rsp1),
		.out       (out1),
		.range_err (range_err1)
	);

endmodule

`default_nettype wire

//--- verilog/mem_read_return.sv
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Read return register for one port
////////////////////////////////////////////////////////////////////////////

module mem_read_return
	import mem_types_pkg::*, mem_bus_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  mem_rsp_t  rsp,
	output mem_data_t out,
	output logic      range_err
);

	// Word to present on a read
	mem_data_t load_data;

	// Missing banks read as zero
	assign load_data = rsp.in_range ? rsp.rdata : '0;

	////////////////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			out       <= '0;
			range_err <= 1'b0;
		end else if (rsp.valid) begin
			// New read result
			out       <= load_data;
			// Flag set for one cycle per bad read
			range_err <= ~rsp.in_range;
		end else begin
			// Idle cycle keeps the last word
			range_err <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/mem_bank_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_defines.svh"

////////////////////////////////////////////////////////////////////////////
// Banked dual port storage
////////////////////////////////////////////////////////////////////////////

module mem_bank_array
	import mem_types_pkg::*, mem_bus_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  mem_req_t req0,
	input  mem_req_t req1,
	output mem_rsp_t rsp0,
	output mem_rsp_t rsp1
);

	// All 30 banks in one array
	// Bank b, offset o lives at b * bank size + o
	mem_data_t mem_q [`MEM_WORDS];

	// Flat word index per port
	mem_addr_t idx0;
	mem_addr_t idx1;

	// Read requests
	logic rd0;
	logic rd1;

	// Write requests that hit a real bank
	logic wr0_req;
	logic wr1;

	// Both ports point at one word
	logic same_word;

	// Port 0 write after collision check
	logic wr0;

	////////////////////////////////////////////////////////////////////////
	// Address and request decode
	////////////////////////////////////////////////////////////////////////

	// Bank size is a power of two
	// Concatenation equals bank * size + offset
	function automatic mem_addr_t word_index(input mem_req_t req);
		return {req.bank, req.offset};
	endfunction

	assign idx0 = word_index(req0);
	assign idx1 = word_index(req1);

	// Reads return a response even out of range
	assign rd0 = req0.valid & ~req0.write;
	assign rd1 = req1.valid & ~req1.write;

	// Out of range writes are dropped here
	assign wr0_req = req0.valid & req0.write & req0.in_range;
	assign wr1     = req1.valid & req1.write & req1.in_range;

	assign same_word = (idx0 == idx1);

	// Data port wins a write collision
	assign wr0 = wr0_req & ~(wr1 & same_word);

	////////////////////////////////////////////////////////////////////////
	// Storage writes
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr0) begin
			mem_q[idx0] <= req0.wdata;
		end
		if (wr1) begin
			mem_q[idx1] <= req1.wdata;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Read responses
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			rsp0.valid <= 1'b0;
			rsp1.valid <= 1'b0;
		end else begin
			rsp0.valid <= rd0;
			rsp1.valid <= rd1;
		end

		// Range flag rides along with the read
		rsp0.in_range <= req0.in_range;
		rsp1.in_range <= req1.in_range;

		// Array value before this edge's writes
		// Gives old data when the other port writes the same word
		if (rd0 && req0.in_range) begin
			rsp0.rdata <= mem_q[idx0];
		end
		if (rd1 && req1.in_range) begin
			rsp1.rdata <= mem_q[idx1];
		end
	end

endmodule

`default_nettype wire

//--- verilog/mem_port_front.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_defines.svh"

////////////////////////////////////////////////////////////////////////////
// Request register for one port
////////////////////////////////////////////////////////////////////////////

module mem_port_front
	import mem_types_pkg::*, mem_bus_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      en,
	input  logic      we,
	input  mem_addr_t addr,
	input  mem_data_t data,
	output mem_req_t  req
);

	// Address fields
	mem_bank_t   addr_bank;
	mem_offset_t addr_offset;

	// Bank check result
	logic addr_in_range;

	// Bank number sits in the top bits
	assign addr_bank = addr[`MEM_ADDR_W-1 -: `MEM_BANK_W];

	// Offset in the low bits
	assign addr_offset = addr[`MEM_OFFSET_W-1:0];

	// Banks 30 and 31 do not exist
	assign addr_in_range = (addr_bank < mem_bank_t'(`MEM_BANK_COUNT));

	////////////////////////////////////////////////////////////////////////
	// Request register
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		// Reset clears valid
		if (rst) begin
			req.valid <= 1'b0;
		end else begin
			req.valid <= en;
		end

		// Payload follows the pins every cycle
		// Qualified downstream by valid
		req.write    <= we;
		req.in_range <= addr_in_range;
		req.bank     <= addr_bank;
		req.offset   <= addr_offset;
		req.wdata    <= data;
	end

endmodule

`default_nettype wire

//--- verilog/mem_bus_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Stage to stage bundles
////////////////////////////////////////////////////////////////////////////

package mem_bus_pkg;
	import mem_types_pkg::*;

	// Decoded request
	// Front stage to bank array
	typedef struct packed {
		// Enable was high at the sampling edge
		logic        valid;
		// Write strobe
		logic        write;
		// Bank number names a real bank
		logic        in_range;
		mem_bank_t   bank;
		mem_offset_t offset;
		mem_data_t   wdata;
	} mem_req_t;

	// Read response
	// Bank array to return stage
	typedef struct packed {
		// Set only for reads
		logic      valid;
		// Copied from the request
		logic      in_range;
		mem_data_t rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire

//--- verilog/mem_types_pkg.sv
`default_nettype none

`include "mem_defines.svh"

////////////////////////////////////////////////////////////////////////////
// Basic vector types of the memory ports
////////////////////////////////////////////////////////////////////////////

package mem_types_pkg;

	// Full port address with the bank field on top
	typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

	// One stored word
	typedef logic [`MEM_DATA_W-1:0] mem_data_t;

	// Bank number
	// Values 30 and 31 name no bank
	typedef logic [`MEM_BANK_W-1:0] mem_bank_t;

	// Word index inside a bank
	typedef logic [`MEM_OFFSET_W-1:0] mem_offset_t;

endpackage

`default_nettype wire

//--- verilog/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Port widths
////////////////////////////////////////////////////////////////////////////

`define MEM_ADDR_W 15
`define MEM_DATA_W 18

////////////////////////////////////////////////////////////////////////////
// Address split
////////////////////////////////////////////////////////////////////////////

// Upper address bits pick the bank
`define MEM_BANK_W 5
// Lower address bits pick the word in that bank
`define MEM_OFFSET_W 10

// Only 30 of the 32 nameable banks exist
`define MEM_BANK_COUNT 30
`define MEM_BANK_SIZE (1 << `MEM_OFFSET_W)

// Flattened storage depth
`define MEM_WORDS (`MEM_BANK_COUNT * `MEM_BANK_SIZE)

`endif
